// File: flist.f
+incdir+verification
common/axisStreamPkg.sv
common/axisRulePkg.sv
logic/byteClassifier.sv
logic/eventCounters.sv
logic/violationRecorder.sv
monitor/handshakeChecker.sv
monitor/axisProtocolMonitor.sv
verification/tbAxisMonitor.sv

// File: Makefile
# Verilator build and run of the AXI4-Stream monitor testbench

SOURCES := $(shell grep -v '^+' flist.f) verification/tbAxisModel.svh

obj_dir/VtbAxisMonitor: $(SOURCES) flist.f
	verilator --binary -j 0 --top-module tbAxisMonitor -f flist.f

run: obj_dir/VtbAxisMonitor
	./obj_dir/VtbAxisMonitor | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: verification/tbAxisModel.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected flags and counters of the stream monitor, stepped once per
// rising ACLK from the values the testbench drives. Included in the tb top.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_AXIS_MODEL_SVH
`define TB_AXIS_MODEL_SVH

axisRulePkg::ruleFlagsT expFlags;
logic                   expSeen;
axisRulePkg::ruleT      expFirst;
axisRulePkg::countT     expTransfers;
axisRulePkg::countT     expPackets;
axisRulePkg::countT     expDataBytes;
axisRulePkg::countT     expPosBytes;
axisRulePkg::countT     expNullBytes;
logic                   mFirstSample;                  // next sample leaves reset
logic                   mPrevStalled;
int                     mStallRun;                     // stalled samples in a row
logic [56:0]            mPrevPayload;                  // all beat fields packed

function automatic axisRulePkg::countT satAdd(input axisRulePkg::countT a, input int b);
   int sum;
   sum = int'(a) + b;
   return (sum > 65535) ? 16'hFFFF : axisRulePkg::countT'(sum);
endfunction

function automatic axisRulePkg::ruleT lowestRule(input axisRulePkg::ruleFlagsT hits);
   for (int idx = 0; idx < axisRulePkg::RuleCount; idx++) begin
      if (hits[idx]) return axisRulePkg::ruleT'(idx);
   end
   return axisRulePkg::ruleValidDrop;
endfunction

task automatic modelStep();
   axisRulePkg::ruleFlagsT hits;
   axisRulePkg::ruleFlagsT base;
   logic [56:0]            payload;
   logic                   stalledNow;
   int                     dataN;
   int                     posN;
   int                     nullN;
   hits       = '0;
   dataN      = 0;
   posN       = 0;
   nullN      = 0;
   payload    = {TDATA, TSTRB, TKEEP, TLAST, TID, TDEST, TUSER};
   stalledNow = TVALID && !TREADY;
   if (OPT_RESET || clearStatus) begin
      expSeen      = 1'b0;
      expFirst     = axisRulePkg::ruleValidDrop;
      expTransfers = '0;
      expPackets   = '0;
      expDataBytes = '0;
      expPosBytes  = '0;
      expNullBytes = '0;
   end
   if (OPT_RESET) begin
      expFlags     = '0;
      mFirstSample = 1'b1;
      mPrevStalled = 1'b0;
      mStallRun    = 0;
   end else begin
      if (mPrevStalled && !TVALID) hits[axisRulePkg::ruleValidDrop] = 1'b1;
      if (mPrevStalled && TVALID && payload != mPrevPayload)
         hits[axisRulePkg::rulePayloadChange] = 1'b1;
      for (int lane = 0; lane < axisStreamPkg::DataBytes; lane++) begin
         if (TKEEP[lane] && TSTRB[lane]) dataN++;
         if (TKEEP[lane] && !TSTRB[lane]) posN++;
         if (!TKEEP[lane] && !TSTRB[lane]) nullN++;
         if (TVALID && !TKEEP[lane] && TSTRB[lane])
            hits[axisRulePkg::ruleReservedByte] = 1'b1;
      end
      if (mFirstSample && TVALID) hits[axisRulePkg::ruleResetExit] = 1'b1;
      mStallRun = stalledNow ? mStallRun + 1 : 0;
      if (mStallRun == MaxWaits + 1) hits[axisRulePkg::ruleStallTimeout] = 1'b1;
      base = clearStatus ? '0 : expFlags;
      if (base == '0 && hits != '0) begin
         expSeen  = 1'b1;                               // first break since clear
         expFirst = lowestRule(hits);
      end
      expFlags = base | hits;
      if (TVALID && TREADY) begin
         expTransfers = satAdd(expTransfers, 1);
         expPackets   = satAdd(expPackets, TLAST ? 1 : 0);
         expDataBytes = satAdd(expDataBytes, dataN);
         expPosBytes  = satAdd(expPosBytes, posN);
         expNullBytes = satAdd(expNullBytes, nullN);
      end
      mPrevStalled = stalledNow;
      mFirstSample = 1'b0;
   end
   mPrevPayload = payload;
endtask

`endif

// File: verification/tbAxisMonitor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AXI4-Stream protocol monitor. Drives LFSR traffic and
// directed rule breaks, checks every output against the model each cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tbAxisMonitor;

   localparam int MaxWaits       = 8;
   localparam int TrafficBeats   = 240;                  // legal random cycles
   localparam int DirectedCycles = 2 * 17 + 60;          // two resets plus directed tests
   localparam int CycleLimit     = TrafficBeats + DirectedCycles + 100;

   logic                    ACLK;
   logic                    OPT_RESET;
   logic                    clearStatus;
   axisStreamPkg::dataT     TDATA;
   axisStreamPkg::laneMaskT TSTRB;
   axisStreamPkg::laneMaskT TKEEP;
   logic                    TLAST;
   axisStreamPkg::idT       TID;
   axisStreamPkg::destT     TDEST;
   axisStreamPkg::userT     TUSER;
   logic                    TVALID;
   logic                    TREADY;
   axisRulePkg::ruleFlagsT  violationFlags;
   logic                    violationSeen;
   axisRulePkg::ruleT       firstViolation;
   axisRulePkg::countT      transferCount;
   axisRulePkg::countT      packetCount;
   axisRulePkg::countT      dataByteCount;
   axisRulePkg::countT      positionByteCount;
   axisRulePkg::countT      nullByteCount;
   logic [31:0]             lfsr;
   logic [31:0]             r;
   int                      errorCount;
   int                      checkCount;
   int                      testCount;
   int                      testErrors;               // errors before the current test
   int                      cycleCount;
   int                      stallRun;
   axisRulePkg::countT      dataBefore;
   axisRulePkg::countT      posBefore;

   `include "tbAxisModel.svh"

   axisProtocolMonitor #(
      .MaxWaits (MaxWaits)
   ) axisProtocolMonitor_i (
      .ACLK              (ACLK),
      .OPT_RESET         (OPT_RESET),
      .clearStatus       (clearStatus),
      .TDATA             (TDATA),
      .TSTRB             (TSTRB),
      .TKEEP             (TKEEP),
      .TLAST             (TLAST),
      .TID               (TID),
      .TDEST             (TDEST),
      .TUSER             (TUSER),
      .TVALID            (TVALID),
      .TREADY            (TREADY),
      .violationFlags    (violationFlags),
      .violationSeen     (violationSeen),
      .firstViolation    (firstViolation),
      .transferCount     (transferCount),
      .packetCount       (packetCount),
      .dataByteCount     (dataByteCount),
      .positionByteCount (positionByteCount),
      .nullByteCount     (nullByteCount)
   );

   always #10 ACLK = ~ACLK;                             // 20 ns period

   always @(posedge ACLK) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > CycleLimit) begin
         $display("run timed out after %0d clock cycles", CycleLimit);
         $display("Test FAILED");
         $finish;
      end
   end

   // fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %0d ns %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic compareOutputs();
      checkValue("violationFlags", 32'(violationFlags), 32'(expFlags));
      checkValue("violationSeen", 32'(violationSeen), 32'(expSeen));
      checkValue("firstViolation", 32'(firstViolation), 32'(expFirst));
      checkValue("transferCount", 32'(transferCount), 32'(expTransfers));
      checkValue("packetCount", 32'(packetCount), 32'(expPackets));
      checkValue("dataByteCount", 32'(dataByteCount), 32'(expDataBytes));
      checkValue("positionByteCount", 32'(positionByteCount), 32'(expPosBytes));
      checkValue("nullByteCount", 32'(nullByteCount), 32'(expNullBytes));
   endtask

   // model steps at the edge and outputs are compared at the drive point
   task automatic stepClock();
      @(posedge ACLK);
      modelStep();
      #2;
      compareOutputs();
   endtask

   task automatic randomPayload();
      logic [31:0] v;
      TDATA = randBits(32);
      v = randBits(8);
      TID = v[7:0];
      v = randBits(8);
      TDEST = v[3:0];
      TUSER = v[7:4];
      v = randBits(9);
      TKEEP = v[3:0];
      TSTRB = v[3:0] & v[7:4];                         // strb only on kept lanes
      TLAST = v[8];
   endtask

   task automatic resetDut(input logic validOnExit);
      OPT_RESET = 1'b1;
      TVALID    = 1'b0;
      TREADY    = 1'b0;
      repeat (16) stepClock();
      OPT_RESET = 1'b0;
      TVALID    = validOnExit;                         // first sample after reset
      TREADY    = 1'b1;
      stepClock();
      TVALID = 1'b0;
      TREADY = 1'b0;
   endtask

   task automatic pulseClear();
      clearStatus = 1'b1;
      stepClock();
      clearStatus = 1'b0;
   endtask

   task automatic reportTest(input string name);
      testCount++;
      $display("test %0d %s finished with %0d errors", testCount, name,
               errorCount - testErrors);
      testErrors = errorCount;
   endtask

   initial begin
      lfsr        = 32'h1642;
      errorCount  = 0;
      checkCount  = 0;
      testCount   = 0;
      testErrors  = 0;
      cycleCount  = 0;
      stallRun    = 0;
      r           = '0;
      dataBefore  = '0;
      posBefore   = '0;
      ACLK        = 1'b0;
      OPT_RESET   = 1'b1;
      clearStatus = 1'b0;
      TDATA       = '0;
      TSTRB       = '0;
      TKEEP       = '0;
      TLAST       = 1'b0;
      TID         = '0;
      TDEST       = '0;
      TUSER       = '0;
      TVALID      = 1'b0;
      TREADY      = 1'b0;
      resetDut(1'b0);

      // legal traffic where a stalled beat is held until accepted
      for (int n = 0; n < TrafficBeats; n++) begin
         stepClock();
         stallRun = (TVALID && !TREADY) ? stallRun + 1 : 0;
         if (!TVALID || TREADY) begin
            TVALID = (randBits(2) != 32'd0);
            randomPayload();
         end
         r = randBits(1);
         TREADY = (stallRun >= MaxWaits - 1) || r[0];  // stalls stay under the limit
      end
      TVALID = 1'b0;
      stepClock();
      checkValue("violationFlags", 32'(violationFlags), 32'd0);
      reportTest("legal random traffic");

      // payload change then valid drop inside one stalled beat
      TVALID = 1'b1;
      TREADY = 1'b0;
      randomPayload();
      r = randBits(1);
      repeat (r[0] + 1) stepClock();
      r = randBits(1);
      if (r[0]) TDATA = ~TDATA;
      else      TUSER = ~TUSER;
      stepClock();
      r = randBits(1);
      repeat (r[0] + 1) stepClock();
      TVALID = 1'b0;
      stepClock();
      checkValue("violationFlags", 32'(violationFlags), 32'h3);
      checkValue("firstViolation", 32'(firstViolation), 32'(axisRulePkg::rulePayloadChange));
      pulseClear();
      checkValue("violationFlags", 32'(violationFlags), 32'd0);
      reportTest("payload change and valid drop");

      // lanes 0 and 1 data with lane 2 reserved and lane 3 position
      dataBefore = expDataBytes;
      posBefore  = expPosBytes;
      TVALID = 1'b1;
      TREADY = 1'b1;
      randomPayload();
      TKEEP = 4'b1011;
      TSTRB = 4'b0111;
      stepClock();
      TVALID = 1'b0;
      checkValue("violationFlags", 32'(violationFlags), 32'h4);
      checkValue("dataByteCount", 32'(dataByteCount), 32'(dataBefore) + 32'd2);
      checkValue("positionByteCount", 32'(positionByteCount), 32'(posBefore) + 32'd1);
      pulseClear();
      reportTest("reserved byte");

      // MaxWaits stalls are legal and one more trips the timeout
      TVALID = 1'b1;
      TREADY = 1'b0;
      randomPayload();
      repeat (MaxWaits) stepClock();
      TREADY = 1'b1;
      stepClock();
      checkValue("violationFlags", 32'(violationFlags), 32'd0);
      TREADY = 1'b0;
      randomPayload();
      repeat (MaxWaits) stepClock();
      checkValue("violationFlags", 32'(violationFlags), 32'd0);
      stepClock();
      checkValue("violationFlags", 32'(violationFlags), 32'h10);
      TREADY = 1'b1;
      stepClock();
      TVALID = 1'b0;
      TREADY = 1'b0;
      pulseClear();
      reportTest("stall timeout");

      resetDut(1'b1);
      checkValue("violationFlags", 32'(violationFlags), 32'h8);
      checkValue("firstViolation", 32'(firstViolation), 32'(axisRulePkg::ruleResetExit));
      pulseClear();
      TVALID = 1'b1;
      randomPayload();
      repeat (2) stepClock();
      TVALID = 1'b0;                                   // drop with reserved lane pattern
      TKEEP  = 4'b0000;
      TSTRB  = 4'b0001;
      stepClock();
      checkValue("firstViolation", 32'(firstViolation), 32'(axisRulePkg::ruleValidDrop));
      pulseClear();
      TVALID = 1'b1;
      randomPayload();
      stepClock();
      TKEEP = 4'b0000;                                 // change and reserved on one sample
      TSTRB = 4'b0001;
      stepClock();
      checkValue("violationFlags", 32'(violationFlags), 32'h6);
      checkValue("firstViolation", 32'(firstViolation), 32'(axisRulePkg::rulePayloadChange));
      TREADY = 1'b1;
      stepClock();
      TVALID = 1'b0;
      TREADY = 1'b0;
      pulseClear();
      reportTest("reset exit and priority");

      $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: monitor/axisProtocolMonitor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Passive AXI4-Stream protocol monitor. Connect all stream signals as inputs;
// sticky violation flags and transfer/byte counters come out one cycle later.
// MaxWaits sets how many stalled cycles are tolerated before TREADY.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module axisProtocolMonitor #(
   parameter int unsigned MaxWaits = 16           // legal range 1 to 255
) (
   input  wire                        ACLK,
   input  wire                        OPT_RESET,
   input  wire                        clearStatus,   // level, clears flags and counts
   input  wire axisStreamPkg::dataT     TDATA,
   input  wire axisStreamPkg::laneMaskT TSTRB,
   input  wire axisStreamPkg::laneMaskT TKEEP,
   input  wire                        TLAST,
   input  wire axisStreamPkg::idT       TID,
   input  wire axisStreamPkg::destT     TDEST,
   input  wire axisStreamPkg::userT     TUSER,
   input  wire                        TVALID,
   input  wire                        TREADY,
   output axisRulePkg::ruleFlagsT     violationFlags,
   output logic                       violationSeen,
   output axisRulePkg::ruleT          firstViolation,
   output axisRulePkg::countT         transferCount,
   output axisRulePkg::countT         packetCount,
   output axisRulePkg::countT         dataByteCount,
   output axisRulePkg::countT         positionByteCount,
   output axisRulePkg::countT         nullByteCount
);

   axisRulePkg::ruleFlagsT    checkerHits;       // temporal rules
   axisRulePkg::ruleFlagsT    allHits;           // plus the reserved-byte rule
   logic                      reservedHit;
   axisStreamPkg::laneCountT  dataLanes;
   axisStreamPkg::laneCountT  positionLanes;
   axisStreamPkg::laneCountT  nullLanes;

   // reserved lane combination is found by the classifier, not the checker
   assign allHits = checkerHits
                  | (axisRulePkg::ruleFlagsT'(reservedHit) << axisRulePkg::ruleReservedByte);

   handshakeChecker #(
      .MaxWaits (MaxWaits)
   ) handshakeChecker_i (
      .ACLK      (ACLK),
      .OPT_RESET (OPT_RESET),
      .TDATA     (TDATA),
      .TSTRB     (TSTRB),
      .TKEEP     (TKEEP),
      .TLAST     (TLAST),
      .TID       (TID),
      .TDEST     (TDEST),
      .TUSER     (TUSER),
      .TVALID    (TVALID),
      .TREADY    (TREADY),
      .ruleHits  (checkerHits)
   );

   byteClassifier byteClassifier_i (
      .TVALID        (TVALID),
      .TSTRB         (TSTRB),
      .TKEEP         (TKEEP),
      .dataLanes     (dataLanes),
      .positionLanes (positionLanes),
      .nullLanes     (nullLanes),
      .reservedHit   (reservedHit)
   );

   eventCounters eventCounters_i (
      .ACLK              (ACLK),
      .OPT_RESET         (OPT_RESET),
      .clearStatus       (clearStatus),
      .TVALID            (TVALID),
      .TREADY            (TREADY),
      .TLAST             (TLAST),
      .dataLanes         (dataLanes),
      .positionLanes     (positionLanes),
      .nullLanes         (nullLanes),
      .transferCount     (transferCount),
      .packetCount       (packetCount),
      .dataByteCount     (dataByteCount),
      .positionByteCount (positionByteCount),
      .nullByteCount     (nullByteCount)
   );

   violationRecorder violationRecorder_i (
      .ACLK           (ACLK),
      .OPT_RESET      (OPT_RESET),
      .clearStatus    (clearStatus),
      .ruleHits       (allHits),
      .violationFlags (violationFlags),
      .violationSeen  (violationSeen),
      .firstViolation (firstViolation)
   );

endmodule

`default_nettype wire

// File: monitor/handshakeChecker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Temporal AXI4-Stream rules: TVALID held until handshake, payload stable
// while stalled, TVALID low on the first sample after reset, and TREADY
// within MaxWaits stalled cycles. Hits are combinational, same cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module handshakeChecker #(
   parameter int unsigned MaxWaits = 16           // stalled samples tolerated
) (
   input  wire                        ACLK,
   input  wire                        OPT_RESET,
   input  wire axisStreamPkg::dataT     TDATA,
   input  wire axisStreamPkg::laneMaskT TSTRB,
   input  wire axisStreamPkg::laneMaskT TKEEP,
   input  wire                        TLAST,
   input  wire axisStreamPkg::idT       TID,
   input  wire axisStreamPkg::destT     TDEST,
   input  wire axisStreamPkg::userT     TUSER,
   input  wire                        TVALID,
   input  wire                        TREADY,
   output axisRulePkg::ruleFlagsT     ruleHits       // reserved-byte bit stays 0
);

   logic                      stalled;
   logic                      prevStalled;       // last sample was stalled
   logic                      firstSample;       // set while in reset
   logic                      timeoutFired;      // this stall already reported
   logic                      payloadDiffers;
   axisStreamPkg::dataT       prevData;
   axisStreamPkg::laneMaskT   prevStrb;
   axisStreamPkg::laneMaskT   prevKeep;
   logic                      prevLast;
   axisStreamPkg::idT         prevId;
   axisStreamPkg::destT       prevDest;
   axisStreamPkg::userT       prevUser;
   axisRulePkg::waitCountT    waitCount;         // stalled samples before this one

   assign stalled = TVALID && !TREADY;

   // any field of the beat moved since the last sample
   assign payloadDiffers = (TDATA != prevData) || (TSTRB != prevStrb)
                        || (TKEEP != prevKeep) || (TLAST != prevLast)
                        || (TID != prevId) || (TDEST != prevDest)
                        || (TUSER != prevUser);

   always_ff @(posedge ACLK) begin
      if (OPT_RESET) begin
         prevStalled  <= 1'b0;
         firstSample  <= 1'b1;                    // next sample is reset exit
         waitCount    <= '0;
         timeoutFired <= 1'b0;
      end else begin
         prevStalled  <= stalled;
         firstSample  <= 1'b0;
         if (!stalled) begin
            waitCount <= '0;                      // handshake or idle ends the stall
         end else begin
            waitCount <= waitCount + 1'b1;        // compared only up to MaxWaits
         end
         timeoutFired <= stalled
                      && (timeoutFired || ruleHits[axisRulePkg::ruleStallTimeout]);
      end
   end

   // payload snapshot compared only after a stalled sample
   always_ff @(posedge ACLK) begin
      prevData <= TDATA;
      prevStrb <= TSTRB;
      prevKeep <= TKEEP;
      prevLast <= TLAST;
      prevId   <= TID;
      prevDest <= TDEST;
      prevUser <= TUSER;
   end

   always_comb begin
      ruleHits = '0;
      ruleHits[axisRulePkg::ruleValidDrop]     = prevStalled && !TVALID;
      ruleHits[axisRulePkg::rulePayloadChange] = prevStalled && TVALID && payloadDiffers;
      ruleHits[axisRulePkg::ruleResetExit]     = firstSample && TVALID;
      // (MaxWaits+1)th stalled sample in a row
      ruleHits[axisRulePkg::ruleStallTimeout]  =
         stalled && !timeoutFired && (waitCount == axisRulePkg::waitCountT'(MaxWaits));
   end

endmodule

`default_nettype wire

// File: logic/violationRecorder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sticky per-rule violation flags and the code of the first rule broken.
// On simultaneous hits the lowest rule index is taken as the first.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module violationRecorder (
   input  wire                         ACLK,
   input  wire                         OPT_RESET,
   input  wire                         clearStatus,
   input  wire axisRulePkg::ruleFlagsT ruleHits,
   output axisRulePkg::ruleFlagsT      violationFlags,
   output logic                        violationSeen,
   output axisRulePkg::ruleT           firstViolation
);

   axisRulePkg::ruleFlagsT flagsBase;            // flags after a pending clear
   axisRulePkg::ruleT      firstHit;             // lowest index hit this cycle

   assign flagsBase = clearStatus ? '0 : violationFlags;

   always_comb begin
      firstHit = axisRulePkg::ruleValidDrop;
      for (int r = axisRulePkg::RuleCount - 1; r >= 0; r--) begin
         if (ruleHits[r]) begin
            firstHit = axisRulePkg::ruleT'(r);    // lower index overrides
         end
      end
   end

   always_ff @(posedge ACLK) begin
      if (OPT_RESET) begin
         violationFlags <= '0;
         violationSeen  <= 1'b0;
         firstViolation <= axisRulePkg::ruleValidDrop;
      end else begin
         violationFlags <= flagsBase | ruleHits;  // new hit wins over clear
         if (flagsBase == '0) begin
            violationSeen  <= |ruleHits;
            firstViolation <= (|ruleHits) ? firstHit : axisRulePkg::ruleValidDrop;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/eventCounters.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Saturating counters of accepted transfers, packets (TLAST) and byte
// classes. clearStatus zeroes them, but a beat on the same edge still counts.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module eventCounters (
   input  wire                           ACLK,
   input  wire                           OPT_RESET,
   input  wire                           clearStatus,
   input  wire                           TVALID,
   input  wire                           TREADY,
   input  wire                           TLAST,
   input  wire axisStreamPkg::laneCountT dataLanes,
   input  wire axisStreamPkg::laneCountT positionLanes,
   input  wire axisStreamPkg::laneCountT nullLanes,
   output axisRulePkg::countT            transferCount,
   output axisRulePkg::countT            packetCount,
   output axisRulePkg::countT            dataByteCount,
   output axisRulePkg::countT            positionByteCount,
   output axisRulePkg::countT            nullByteCount
);

   logic accepted;                                // handshake this edge

   // next value of one counter, clear first then add, stick at all ones
   function automatic axisRulePkg::countT bump(input axisRulePkg::countT cnt,
                                              input logic clr,
                                              input axisRulePkg::countT inc);
      logic [$bits(axisRulePkg::countT):0] sum;
      sum = {1'b0, (clr ? '0 : cnt)} + inc;
      return sum[$bits(axisRulePkg::countT)] ? '1 : sum[$bits(axisRulePkg::countT)-1:0];
   endfunction

   assign accepted = TVALID && TREADY;

   always_ff @(posedge ACLK) begin
      if (OPT_RESET) begin
         transferCount     <= '0;
         packetCount       <= '0;
         dataByteCount     <= '0;
         positionByteCount <= '0;
         nullByteCount     <= '0;
      end else begin
         transferCount     <= bump(transferCount, clearStatus,
                                   axisRulePkg::countT'(accepted));
         packetCount       <= bump(packetCount, clearStatus,
                                   axisRulePkg::countT'(accepted && TLAST));
         dataByteCount     <= bump(dataByteCount, clearStatus,
                                   accepted ? axisRulePkg::countT'(dataLanes) : '0);
         positionByteCount <= bump(positionByteCount, clearStatus,
                                   accepted ? axisRulePkg::countT'(positionLanes) : '0);
         nullByteCount     <= bump(nullByteCount, clearStatus,
                                   accepted ? axisRulePkg::countT'(nullLanes) : '0);
      end
   end

endmodule

`default_nettype wire

// File: logic/byteClassifier.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sorts the lanes of the current beat by TKEEP/TSTRB into data, position,
// null and reserved, and counts each usable class. Purely combinational.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module byteClassifier (
   input  wire                        TVALID,
   input  wire axisStreamPkg::laneMaskT TSTRB,
   input  wire axisStreamPkg::laneMaskT TKEEP,
   output axisStreamPkg::laneCountT   dataLanes,
   output axisStreamPkg::laneCountT   positionLanes,
   output axisStreamPkg::laneCountT   nullLanes,
   output logic                       reservedHit    // keep low, strb high on a valid beat
);

   always_comb begin
      dataLanes     = '0;
      positionLanes = '0;
      nullLanes     = '0;
      for (int lane = 0; lane < axisStreamPkg::DataBytes; lane++) begin
         case ({TKEEP[lane], TSTRB[lane]})
            2'b11:   dataLanes     = dataLanes + 1'b1;
            2'b10:   positionLanes = positionLanes + 1'b1;
            2'b00:   nullLanes     = nullLanes + 1'b1;
            default: ;                            // reserved lane, counted nowhere
         endcase
      end
   end

   assign reservedHit = TVALID && (|(~TKEEP & TSTRB));

endmodule

`default_nettype wire

// File: common/axisRulePkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rule codes, flag vector and counter types reported by the stream monitor.
// Rule value is both its flag bit index and its priority (lowest wins).
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package axisRulePkg;

   typedef enum logic [2:0] {
      ruleValidDrop     = 3'd0,                   // TVALID fell before handshake
      rulePayloadChange = 3'd1,                   // payload moved during a stall
      ruleReservedByte  = 3'd2,                   // TKEEP low with TSTRB high
      ruleResetExit     = 3'd3,                   // TVALID high on first sample
      ruleStallTimeout  = 3'd4                    // TREADY too late
   } ruleT;

   parameter int RuleCount = 5;

   // one sticky bit per rule, indexed by ruleT
   typedef logic [RuleCount-1:0] ruleFlagsT;

   // event and byte counters, saturate at all ones
   typedef logic [15:0] countT;

   // consecutive stalled samples
   typedef logic [7:0] waitCountT;

endpackage

`default_nettype wire

// File: common/axisStreamPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field types of the monitored AXI4-Stream bus.
// Referenced by scoped name from the monitor blocks and the testbench.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package axisStreamPkg;

   parameter int DataBytes = 4;                  // byte lanes per beat

   // TDATA, one byte per lane
   typedef logic [DataBytes*8-1:0] dataT;

   // TSTRB and TKEEP, one bit per lane
   typedef logic [DataBytes-1:0] laneMaskT;

   typedef logic [7:0] idT;                       // TID
   typedef logic [3:0] destT;                     // TDEST
   typedef logic [3:0] userT;                     // TUSER

   // lanes of one class in a beat, 0 to DataBytes
   typedef logic [2:0] laneCountT;

endpackage

`default_nettype wire
